/* project.f */
logic/issue_cfg_pkg.sv
logic/issue_types_pkg.sv
logic/tag_pool.sv
logic/reg_table.sv
logic/wait_buffer.sv
logic/exec_pipe.sv
logic/issue_top.sv
dv/issue_checker.sv
dv/issue_tb.sv

/* Bender.yml */
package:
  name: issue_stage

sources:
  - logic/issue_cfg_pkg.sv
  - logic/issue_types_pkg.sv
  - logic/tag_pool.sv
  - logic/reg_table.sv
  - logic/wait_buffer.sv
  - logic/exec_pipe.sv
  - logic/issue_top.sv
  - target: test
    files:
      - dv/issue_checker.sv
      - dv/issue_tb.sv

/* dv/issue_tb.sv */
// Issue stage testbench
// Seeded random dispatch stream into the issue stage, with drain and watchdog
`timescale 1ns/1ns
`default_nettype none

module issue_tb import issue_cfg_pkg::*, issue_types_pkg::*; ();

    // ##################################################
    // Run length and limits
    // ##################################################

    localparam int unsigned NumInsts      = 300;
    localparam int unsigned ResetCycles   = 16;
    // Worst case per instruction plus slack for reset and drain
    localparam int unsigned TimeoutCycles =
        ResetCycles + NumInsts * (NumTags + EuLatency + 4) + 200;
    // Longest dependency chain left in flight when stimulus stops
    localparam int unsigned DrainCycles   = NumTags * (EuLatency + 4);
    localparam logic [31:0] Seed          = 32'h950825d3;

    logic  clk;
    logic  rst;
    logic  inst_valid;
    inst_t inst;
    logic  accept;
    tag_t  dispatch_tag;
    logic  wb_valid;
    wb_t   wb;
    logic  all_dst_written;

    logic  drain;
    int    outstanding;
    int    errors;
    logic  report_done;
    int    sent;
    int    drain_wait;

    // 10 ns clock
    initial clk = 1'b0;
    always #5 clk = ~clk;

    issue_top i_issue_top (
        .clk_i             (clk),
        .rst_i             (rst),
        .inst_valid_i      (inst_valid),
        .inst_i            (inst),
        .accept_o          (accept),
        .dispatch_tag_o    (dispatch_tag),
        .wb_valid_o        (wb_valid),
        .wb_o              (wb),
        .all_dst_written_o (all_dst_written)
    );

    issue_checker i_issue_checker (
        .clk_i             (clk),
        .rst_i             (rst),
        .inst_valid_i      (inst_valid),
        .inst_i            (inst),
        .accept_i          (accept),
        .dispatch_tag_i    (dispatch_tag),
        .wb_valid_i        (wb_valid),
        .wb_i              (wb),
        .all_dst_written_i (all_dst_written),
        .drain_i           (drain),
        .outstanding_o     (outstanding),
        .errors_o          (errors),
        .report_o          (report_done)
    );

    // Small register range so that sources often hit earlier destinations
    function automatic inst_t random_inst();
        inst_t r;
        r.subwarp = subwarp_id_t'($urandom_range(0, NumSubwarps - 1));
        r.op      = eu_op_e'($urandom_range(0, 3));
        r.dst     = reg_idx_t'($urandom_range(0, 3));
        for (int k = 0; k < NumOperands; k++) begin
            r.src[k] = reg_idx_t'($urandom_range(0, 3));
        end
        return r;
    endfunction

    // ##################################################
    // Stimulus
    // ##################################################

    initial begin
        void'($urandom(Seed));
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        drain      = 1'b0;
        sent       = 0;
        drain_wait = 0;

        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;

        while (sent < NumInsts) begin
            @(posedge clk);
            if (inst_valid && accept) begin
                sent++;
            end
            // Rejected instruction stays on the bus
            if (!inst_valid || accept) begin
                if (sent < NumInsts && $urandom_range(0, 3) != 0) begin
                    inst_valid <= 1'b1;
                    inst       <= random_inst();
                end else begin
                    inst_valid <= 1'b0;
                end
            end
        end

        // Give the checker one cycle to log the last dispatch
        @(posedge clk);
        // Bounded wait for the remaining writebacks
        while (outstanding != 0 && drain_wait < DrainCycles) begin
            @(posedge clk);
            drain_wait++;
        end
        drain <= 1'b1;
        while (!report_done) begin
            @(posedge clk);
        end

        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TimeoutCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the run finished", TimeoutCycles);
        $display("Regression failed");
        $finish;
    end

endmodule : issue_tb

`default_nettype wire

/* dv/issue_checker.sv */
// Issue stage checker
// Dependency model of the issue stage, checks writebacks, tags and capacity
`timescale 1ns/1ns
`default_nettype none

module issue_checker import issue_cfg_pkg::*, issue_types_pkg::*; (
    input  wire  logic  clk_i,
    input  wire  logic  rst_i,
    // Decoder side of the DUT
    input  wire  logic  inst_valid_i,
    input  wire  inst_t inst_i,
    input  wire  logic  accept_i,
    input  wire  tag_t  dispatch_tag_i,
    // Writeback side of the DUT
    input  wire  logic  wb_valid_i,
    input  wire  wb_t   wb_i,
    input  wire  logic  all_dst_written_i,
    // Run control
    input  wire  logic  drain_i,
    output       int    outstanding_o,
    output       int    errors_o,
    output       logic  report_o
);

    // Per tag state of the model
    logic  out_valid  [NumTags];
    int    seq_of_tag [NumTags];
    inst_t inst_log   [NumTags];
    int    dep_seq    [NumTags][NumOperands];
    tag_t  dep_tag    [NumTags][NumOperands];

    // Newest unfinished producer per subwarp and register
    // A value of -1 marks a register with no producer
    int    newest_seq [NumSubwarps][2**RegIdxWidth];
    tag_t  newest_tag [NumSubwarps][2**RegIdxWidth];

    // Ring of 16 cycles of capacity history
    int    out_hist [16];
    logic  acc_hist [16];
    int    wbv_hist [16];

    int    live;
    int    seq;
    int    wb_count;
    int    cyc;
    logic  reset_seen;
    int    tests_passed;
    int    tests_failed;

    int    err_reset;
    int    err_wb;
    int    err_dep;
    int    err_tag;
    int    err_cap;
    int    err_drain;

    initial begin
        for (int t = 0; t < NumTags; t++) begin
            out_valid[t] = 1'b0;
        end
        for (int w = 0; w < NumSubwarps; w++) begin
            for (int r = 0; r < 2**RegIdxWidth; r++) begin
                newest_seq[w][r] = -1;
            end
        end
        live          = 0;
        seq           = 0;
        wb_count      = 0;
        cyc           = 0;
        reset_seen    = 1'b0;
        tests_passed  = 0;
        tests_failed  = 0;
        err_reset     = 0;
        err_wb        = 0;
        err_dep       = 0;
        err_tag       = 0;
        err_cap       = 0;
        err_drain     = 0;
        outstanding_o = 0;
        errors_o      = 0;
        report_o      = 1'b0;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp, inout int errs);
        if (got !== exp) begin
            $display("Error %s: expected %h got %h (cycle %0d)", name, exp, got, cyc);
            errs++;
        end
    endtask

    task automatic print_result(input string name, input int errs);
        if (errs == 0) begin
            $display("Test %s: PASS", name);
            tests_passed++;
        end else begin
            $display("Test %s: FAIL with %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    // ##################################################
    // Dispatch and writeback model
    // ##################################################

    // Pool hands out the lowest tag that is not outstanding
    task automatic check_dispatch_tag();
        tag_t low;
        low = '0;
        for (int t = NumTags - 1; t >= 0; t--) begin
            if (!out_valid[t]) begin
                low = tag_t'(t);
            end
        end
        if (out_valid[dispatch_tag_i]) begin
            $display("Error dispatch_tag_o: tag %h is still outstanding", dispatch_tag_i);
            err_tag++;
        end else begin
            compare_value("dispatch_tag_o", dispatch_tag_i, low, err_tag);
        end
    endtask

    task automatic retire_writeback();
        tag_t t;
        int   s;
        t = wb_i.tag;
        if (!out_valid[t]) begin
            $display("Writeback for tag %0d arrived while that tag was not outstanding", t);
            err_wb++;
        end else begin
            s = seq_of_tag[t];
            compare_value("wb_o.subwarp", wb_i.subwarp, inst_log[t].subwarp, err_wb);
            compare_value("wb_o.dst", wb_i.dst, inst_log[t].dst, err_wb);
            compare_value("wb_o.op", wb_i.op, inst_log[t].op, err_wb);
            // Producer still outstanding means it did not write back first
            for (int k = 0; k < NumOperands; k++) begin
                if (dep_seq[t][k] >= 0 && out_valid[dep_tag[t][k]]
                    && seq_of_tag[dep_tag[t][k]] == dep_seq[t][k]) begin
                    $display("Instruction %0d wrote back before its producer %0d",
                             s, dep_seq[t][k]);
                    err_dep++;
                end
            end
            out_valid[t] = 1'b0;
            live--;
            wb_count++;
            if (newest_seq[inst_log[t].subwarp][inst_log[t].dst] == s) begin
                newest_seq[inst_log[t].subwarp][inst_log[t].dst] = -1;
            end
        end
    endtask

    // Sources look up the table before the destination takes it over
    task automatic log_dispatch();
        tag_t t;
        t             = dispatch_tag_i;
        out_valid[t]  = 1'b1;
        inst_log[t]   = inst_i;
        seq_of_tag[t] = seq;
        for (int k = 0; k < NumOperands; k++) begin
            dep_seq[t][k] = newest_seq[inst_i.subwarp][inst_i.src[k]];
            dep_tag[t][k] = newest_tag[inst_i.subwarp][inst_i.src[k]];
        end
        newest_seq[inst_i.subwarp][inst_i.dst] = seq;
        newest_tag[inst_i.subwarp][inst_i.dst] = t;
        seq++;
        live++;
    endtask

    // ##################################################
    // Per cycle checks
    // ##################################################

    always @(posedge clk_i) begin
        int   e;
        int   occ;
        logic exp_acc;
        if (rst_i) begin
            cyc = 0;
        end else begin
            if (!reset_seen) begin
                compare_value("accept_o", accept_i, 1, err_reset);
                compare_value("all_dst_written_o", all_dst_written_i, 1, err_reset);
                compare_value("wb_valid_o", wb_valid_i, 0, err_reset);
                print_result("reset", err_reset);
                reset_seen = 1'b1;
            end

            // Buffer fill at cycle e is known once the next EuLatency writebacks are seen
            out_hist[cyc % 16] = live;
            acc_hist[cyc % 16] = accept_i;
            wbv_hist[cyc % 16] = wb_valid_i ? 1 : 0;
            if (cyc >= EuLatency - 1) begin
                e   = cyc - (EuLatency - 1);
                occ = out_hist[e % 16];
                for (int k = 0; k < EuLatency; k++) begin
                    occ -= wbv_hist[(e + k) % 16];
                end
                exp_acc = (out_hist[e % 16] < NumTags) && (occ < WaitDepth);
                compare_value("accept_o", acc_hist[e % 16], exp_acc, err_cap);
            end

            if (inst_valid_i && accept_i) begin
                check_dispatch_tag();
            end
            // Writeback goes first so that a same cycle producer counts as done
            if (wb_valid_i) begin
                retire_writeback();
            end
            if (inst_valid_i && accept_i) begin
                log_dispatch();
            end

            if (drain_i && !report_o) begin
                compare_value("all_dst_written_o", all_dst_written_i, 1, err_drain);
                if (live != 0) begin
                    $display("%0d instructions never wrote back", live);
                    err_wb++;
                end
                print_result("writeback", err_wb);
                print_result("dependency", err_dep);
                print_result("tags", err_tag);
                print_result("capacity", err_cap);
                print_result("drain", err_drain);
                $display("Tests passed %0d, failed %0d, instructions %0d, writebacks %0d",
                         tests_passed, tests_failed, seq, wb_count);
                report_o <= 1'b1;
            end
            cyc++;
        end
        outstanding_o <= live;
        errors_o      <= err_reset + err_wb + err_dep + err_tag + err_cap + err_drain;
    end

endmodule : issue_checker

`default_nettype wire

/* logic/issue_top.sv */
// Issue stage top
// Tag pool, register table, wait buffer and execution pipe
`timescale 1ns/1ns
`default_nettype none

module issue_top import issue_cfg_pkg::*, issue_types_pkg::*; (
    input  wire  logic  clk_i,
    input  wire  logic  rst_i,
    // Decoder
    input  wire  logic  inst_valid_i,
    input  wire  inst_t inst_i,
    output       logic  accept_o,
    output       tag_t  dispatch_tag_o,
    // Writeback
    output       logic  wb_valid_o,
    output       wb_t   wb_o,
    output       logic  all_dst_written_o
);

    logic                   free_avail;
    logic                   space;
    logic                   dispatch;
    logic [NumOperands-1:0] operands_ready;
    tag_t [NumOperands-1:0] operands_tag;
    logic                   issue_valid;
    wb_t                    issue;

    // Needs both a tag and a slot
    assign accept_o = free_avail && space;
    assign dispatch = inst_valid_i && accept_o;

    tag_pool i_tag_pool (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .alloc_i       (dispatch),
        .free_avail_o  (free_avail),
        .free_tag_o    (dispatch_tag_o),
        .release_i     (wb_valid_o),
        .release_tag_i (wb_o.tag)
    );

    reg_table i_reg_table (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .insert_i          (dispatch),
        .tag_i             (dispatch_tag_o),
        .inst_i            (inst_i),
        .eu_valid_i        (wb_valid_o),
        .eu_tag_i          (wb_o.tag),
        .operands_ready_o  (operands_ready),
        .operands_tag_o    (operands_tag),
        .all_dst_written_o (all_dst_written_o)
    );

    wait_buffer i_wait_buffer (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .write_i          (dispatch),
        .tag_i            (dispatch_tag_o),
        .inst_i           (inst_i),
        .operands_ready_i (operands_ready),
        .operands_tag_i   (operands_tag),
        .wb_valid_i       (wb_valid_o),
        .wb_tag_i         (wb_o.tag),
        .space_o          (space),
        .issue_valid_o    (issue_valid),
        .issue_o          (issue)
    );

    exec_pipe i_exec_pipe (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o)
    );

endmodule : issue_top

`default_nettype wire

/* logic/exec_pipe.sv */
// Execution pipe
// Fixed latency shift pipeline that turns issues into writebacks
`timescale 1ns/1ns
`default_nettype none

module exec_pipe import issue_cfg_pkg::*, issue_types_pkg::*; (
    input  wire  logic clk_i,
    input  wire  logic rst_i,
    // From wait buffer
    input  wire  logic issue_valid_i,
    input  wire  wb_t  issue_i,
    // Writeback
    output       logic wb_valid_o,
    output       wb_t  wb_o
);

    // One valid bit per stage, several in flight
    logic [EuLatency-1:0] valid_q;
    wb_t  [EuLatency-1:0] stage_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= issue_valid_i;
            for (int i = 1; i < EuLatency; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Payload shifts with its valid bit
    always_ff @(posedge clk_i) begin
        stage_q[0] <= issue_i;
        for (int i = 1; i < EuLatency; i++) begin
            stage_q[i] <= stage_q[i-1];
        end
    end

    // Last stage is the writeback
    assign wb_valid_o = valid_q[EuLatency-1];
    assign wb_o       = stage_q[EuLatency-1];

endmodule : exec_pipe

`default_nettype wire

/* logic/wait_buffer.sv */
// Wait buffer
// Parks dispatched instructions until their sources are written back
// Issues the oldest ready slot each cycle
`timescale 1ns/1ns
`default_nettype none

module wait_buffer import issue_cfg_pkg::*, issue_types_pkg::*; (
    input  wire  logic                   clk_i,
    input  wire  logic                   rst_i,
    // Dispatch
    input  wire  logic                   write_i,
    input  wire  tag_t                   tag_i,
    input  wire  inst_t                  inst_i,
    input  wire  logic [NumOperands-1:0] operands_ready_i,
    input  wire  tag_t [NumOperands-1:0] operands_tag_i,
    // Writeback wakeup
    input  wire  logic                   wb_valid_i,
    input  wire  tag_t                   wb_tag_i,
    // Status and issue
    output       logic                   space_o,
    output       logic                   issue_valid_o,
    output       wb_t                    issue_o
);

    typedef logic [SlotIdxWidth-1:0] slot_idx_t;

    // Age counts younger occupied slots, oldest has the highest value
    typedef struct packed {
        inst_t                  inst;
        tag_t                   tag;
        logic [NumOperands-1:0] rdy;
        tag_t [NumOperands-1:0] wait_tag;
        slot_idx_t              age;
    } slot_t;

    slot_state_e [WaitDepth-1:0] state_q;
    slot_state_e [WaitDepth-1:0] state_d;
    slot_t       [WaitDepth-1:0] slot_q;
    slot_t       [WaitDepth-1:0] slot_d;

    slot_idx_t free_idx;
    slot_idx_t issue_idx;
    slot_idx_t issue_age;
    logic      write_en;

    // ################################################
    // Free slot and oldest ready slot
    // ################################################

    always_comb begin
        space_o  = 1'b0;
        free_idx = '0;
        for (int s = WaitDepth - 1; s >= 0; s--) begin
            if (state_q[s] == SLOT_FREE) begin
                space_o  = 1'b1;
                free_idx = slot_idx_t'(s);
            end
        end
    end

    assign write_en = write_i && space_o;

    always_comb begin
        issue_valid_o = 1'b0;
        issue_idx     = '0;
        issue_age     = '0;
        for (int s = 0; s < WaitDepth; s++) begin
            if (state_q[s] == SLOT_WAIT && &slot_q[s].rdy
                && (!issue_valid_o || slot_q[s].age > issue_age)) begin
                issue_valid_o = 1'b1;
                issue_idx     = slot_idx_t'(s);
                issue_age     = slot_q[s].age;
            end
        end
    end

    always_comb begin
        issue_o = '0;
        if (issue_valid_o) begin
            issue_o.tag     = slot_q[issue_idx].tag;
            issue_o.subwarp = slot_q[issue_idx].inst.subwarp;
            issue_o.dst     = slot_q[issue_idx].inst.dst;
            issue_o.op      = slot_q[issue_idx].inst.op;
        end
    end

    // ################################################
    // Slot update
    // ################################################

    always_comb begin
        state_d = state_q;
        slot_d  = slot_q;

        for (int s = 0; s < WaitDepth; s++) begin
            if (state_q[s] == SLOT_WAIT) begin
                // Wake operands waiting on this writeback
                for (int op = 0; op < NumOperands; op++) begin
                    if (wb_valid_i && !slot_q[s].rdy[op]
                        && slot_q[s].wait_tag[op] == wb_tag_i) begin
                        slot_d[s].rdy[op] = 1'b1;
                    end
                end
                // Keep ages dense
                if (write_en) begin
                    slot_d[s].age = slot_d[s].age + slot_idx_t'(1);
                end
                if (issue_valid_o && slot_q[s].age > issue_age) begin
                    slot_d[s].age = slot_d[s].age - slot_idx_t'(1);
                end
            end
        end

        if (issue_valid_o) begin
            state_d[issue_idx] = SLOT_FREE;
        end

        // New entry is the youngest
        if (write_en) begin
            state_d[free_idx]         = SLOT_WAIT;
            slot_d[free_idx].inst     = inst_i;
            slot_d[free_idx].tag      = tag_i;
            slot_d[free_idx].rdy      = operands_ready_i;
            slot_d[free_idx].wait_tag = operands_tag_i;
            slot_d[free_idx].age      = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= {WaitDepth{SLOT_FREE}};
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        slot_q <= slot_d;
    end

endmodule : wait_buffer

`default_nettype wire

/* logic/reg_table.sv */
// Register table
// Maps each register to its newest producer tag and reports operand readiness
`timescale 1ns/1ns
`default_nettype none

module reg_table import issue_cfg_pkg::*, issue_types_pkg::*; (
    input  wire  logic                   clk_i,
    input  wire  logic                   rst_i,
    // Dispatch
    input  wire  logic                   insert_i,
    input  wire  tag_t                   tag_i,
    input  wire  inst_t                  inst_i,
    // Writeback
    input  wire  logic                   eu_valid_i,
    input  wire  tag_t                   eu_tag_i,
    // To wait buffer
    output       logic [NumOperands-1:0] operands_ready_o,
    output       tag_t [NumOperands-1:0] operands_tag_o,
    // No outstanding producer
    output       logic                   all_dst_written_o
);

    // ################################################
    // Entry storage
    // ################################################

    typedef struct packed {
        subwarp_id_t subwarp;
        reg_idx_t    dst;
        tag_t        producer;
    } entry_t;

    logic   [NumTags-1:0] valid_q;
    logic   [NumTags-1:0] valid_d;
    entry_t [NumTags-1:0] table_q;
    entry_t [NumTags-1:0] table_d;

    // Table empty means every result has reached the register file
    assign all_dst_written_o = ~|valid_q;

    // ################################################
    // Operand lookup
    // ################################################

    always_comb begin
        logic hit;
        for (int op = 0; op < NumOperands; op++) begin
            hit                  = 1'b0;
            operands_ready_o[op] = 1'b1;
            operands_tag_o[op]   = '0;
            // At most one entry per subwarp and register
            for (int e = 0; e < NumTags; e++) begin
                if (!hit && valid_q[e]
                    && table_q[e].subwarp == inst_i.subwarp
                    && table_q[e].dst == inst_i.src[op]) begin
                    hit                  = 1'b1;
                    operands_ready_o[op] = 1'b0;
                    operands_tag_o[op]   = table_q[e].producer;
                end
            end
            // Producer writing back right now counts as ready
            if (hit && eu_valid_i && operands_tag_o[op] == eu_tag_i) begin
                operands_ready_o[op] = 1'b1;
            end
        end
    end

    // ################################################
    // Clear and insert
    // ################################################

    always_comb begin
        logic placed;
        valid_d = valid_q;
        table_d = table_q;
        placed  = 1'b0;

        // Writeback first so a stale entry can be reused below
        if (eu_valid_i) begin
            for (int e = 0; e < NumTags; e++) begin
                if (valid_q[e] && table_q[e].producer == eu_tag_i) begin
                    valid_d[e] = 1'b0;
                end
            end
        end

        if (insert_i) begin
            // Same register already tracked, take over as newest producer
            for (int e = 0; e < NumTags; e++) begin
                if (!placed && valid_d[e]
                    && table_q[e].subwarp == inst_i.subwarp
                    && table_q[e].dst == inst_i.dst) begin
                    table_d[e].producer = tag_i;
                    placed              = 1'b1;
                end
            end
            // Otherwise lowest free entry
            for (int e = 0; e < NumTags; e++) begin
                if (!placed && !valid_d[e]) begin
                    valid_d[e]          = 1'b1;
                    table_d[e].subwarp  = inst_i.subwarp;
                    table_d[e].dst      = inst_i.dst;
                    table_d[e].producer = tag_i;
                    placed              = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // Payload follows valid bits
    always_ff @(posedge clk_i) begin
        table_q <= table_d;
    end

endmodule : reg_table

`default_nettype wire

/* logic/tag_pool.sv */
// Producer tag pool
// Hands out the lowest free tag and takes back written back tags
`timescale 1ns/1ns
`default_nettype none

module tag_pool import issue_cfg_pkg::*, issue_types_pkg::*; (
    input  wire  logic clk_i,
    input  wire  logic rst_i,
    // Allocation side
    input  wire  logic alloc_i,
    output       logic free_avail_o,
    output       tag_t free_tag_o,
    // Release from writeback
    input  wire  logic release_i,
    input  wire  tag_t release_tag_i
);

    // One bit per tag, set while the tag is in flight
    logic [NumTags-1:0] busy_q;
    logic [NumTags-1:0] busy_d;

    // Lowest free tag wins
    always_comb begin
        free_avail_o = 1'b0;
        free_tag_o   = '0;
        for (int t = NumTags - 1; t >= 0; t--) begin
            if (!busy_q[t]) begin
                free_avail_o = 1'b1;
                free_tag_o   = tag_t'(t);
            end
        end
    end

    always_comb begin
        busy_d = busy_q;
        // Released tag is free again next cycle
        if (release_i) begin
            busy_d[release_tag_i] = 1'b0;
        end
        if (alloc_i && free_avail_o) begin
            busy_d[free_tag_o] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

endmodule : tag_pool

`default_nettype wire

/* logic/issue_types_pkg.sv */
// Issue stage types
// Index types, opcodes and the instruction and writeback records
`default_nettype none

package issue_types_pkg;

    import issue_cfg_pkg::*;

    typedef logic [TagWidth-1:0]       tag_t;
    typedef logic [RegIdxWidth-1:0]    reg_idx_t;
    typedef logic [SubwarpIdWidth-1:0] subwarp_id_t;

    // Passed through the stage untouched
    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_MUL  = 2'd1,
        OP_LOAD = 2'd2,
        OP_MOVE = 2'd3
    } eu_op_e;

    // Decoded instruction from the decoder
    typedef struct packed {
        subwarp_id_t                    subwarp;
        eu_op_e                         op;
        reg_idx_t                       dst;
        reg_idx_t [NumOperands-1:0]     src;
    } inst_t;

    // Issued and written back instruction
    typedef struct packed {
        tag_t        tag;
        subwarp_id_t subwarp;
        reg_idx_t    dst;
        eu_op_e      op;
    } wb_t;

    typedef enum logic {
        SLOT_FREE = 1'b0,
        SLOT_WAIT = 1'b1
    } slot_state_e;

endpackage : issue_types_pkg

`default_nettype wire

/* logic/issue_cfg_pkg.sv */
// Issue stage configuration
// Sizing constants shared by all issue stage blocks
`default_nettype none

package issue_cfg_pkg;

    // Producer tags and register table entries
    localparam int unsigned NumTags      = 8;
    // Wait buffer slots
    localparam int unsigned WaitDepth    = 4;
    localparam int unsigned RegIdxWidth  = 5;
    localparam int unsigned NumSubwarps  = 4;
    // Source operands per instruction
    localparam int unsigned NumOperands  = 2;
    // Cycles from issue to writeback
    localparam int unsigned EuLatency    = 3;

    // Derived widths
    localparam int unsigned TagWidth       = $clog2(NumTags);
    localparam int unsigned SubwarpIdWidth = $clog2(NumSubwarps);
    // Slot index and relative age share one width
    localparam int unsigned SlotIdxWidth   = $clog2(WaitDepth);

endpackage : issue_cfg_pkg

`default_nettype wire
